// File: logic/net_cfg_pkg.sv
/*
 * protocol widths for the host request router
 * stream selector codes for the rdma and tcp paths
 */
`default_nettype none

package net_cfg_pkg;

    // stream selector and its two codes
    localparam int STRM_BITS = 1;
    localparam logic [STRM_BITS-1:0] STRM_RDMA = 1'b0;
    localparam logic [STRM_BITS-1:0] STRM_TCP = 1'b1;

    // request word fields
    localparam int CTX_BITS = 16;
    localparam int VADDR_BITS = 48;
    localparam int LEN_BITS = 28;

    // protocol sequence state
    localparam int PSN_BITS = 24;
    localparam int SEQ_BITS = 32;
    localparam int OPC_BITS = 4;
    localparam int QPN_BITS = 12;

endpackage

`default_nettype wire

// File: logic/net_types_pkg.sv
/*
 * request types for the host request router
 *   rdma_ctx_t / tcp_ctx_t  two readings of the context word
 *   ctx_u                   union of both readings
 *   dreq_t, tcp_req_t       queued request and tcp path request
 *   rdma_out_t, tcp_out_t   stamped sequencer outputs
 */
`default_nettype none

package net_types_pkg;

    // rdma reading of the context, opcode on top
    typedef struct packed {
        logic [net_cfg_pkg::OPC_BITS-1:0] opcode;
        logic [net_cfg_pkg::QPN_BITS-1:0] qpn;
    } rdma_ctx_t;

    // tcp reading, the whole word is the session id
    typedef struct packed {
        logic [net_cfg_pkg::CTX_BITS-1:0] sid;
    } tcp_ctx_t;

    // decoded one way or the other by the stream field
    typedef union packed {
        rdma_ctx_t rdma;
        tcp_ctx_t tcp;
    } ctx_u;

    // what the tcp path carries
    typedef struct packed {
        logic [net_cfg_pkg::CTX_BITS-1:0] sid;
        logic [net_cfg_pkg::VADDR_BITS-1:0] vaddr;
        logic [net_cfg_pkg::LEN_BITS-1:0] len;
    } tcp_req_t;

    // full host request, as queued
    typedef struct packed {
        logic [net_cfg_pkg::STRM_BITS-1:0] strm;
        ctx_u ctx;
        logic [net_cfg_pkg::VADDR_BITS-1:0] vaddr;
        logic [net_cfg_pkg::LEN_BITS-1:0] len;
    } dreq_t;

    typedef struct packed {
        dreq_t req;
        logic [net_cfg_pkg::PSN_BITS-1:0] psn;
    } rdma_out_t;

    typedef struct packed {
        tcp_req_t req;
        logic [net_cfg_pkg::SEQ_BITS-1:0] seq;
    } tcp_out_t;

endpackage

`default_nettype wire

// File: logic/meta_intf.sv
/*
 * valid/ready metadata interface
 * master modport drives valid and data, slave modport drives ready
 */
`timescale 1ns/10ps
`default_nettype none

interface meta_intf #(
    parameter int DATA_BITS = 32
) ();

    // transfer on a clock edge with valid and ready both high
    logic valid;
    logic ready;
    // held stable from valid until the transfer
    logic [DATA_BITS-1:0] data;

    // sending side
    modport m (
        output valid,
        output data,
        input  ready
    );

    // receiving side
    modport s (
        input  valid,
        input  data,
        output ready
    );

endinterface

`default_nettype wire

// File: logic/meta_reg.sv
/*
 * register slice for a valid/ready metadata stream
 * main register plus one skid entry, registered ready
 */
`timescale 1ns/10ps
`default_nettype none

module meta_reg #(
    parameter int DATA_BITS = 32
) (
    input  wire   aclk,
    input  wire   rst,
    meta_intf.s   s_meta,
    meta_intf.m   m_meta
);

    logic main_valid;
    logic skid_valid;
    logic [DATA_BITS-1:0] main_data;
    logic [DATA_BITS-1:0] skid_data;
    // output slot empty or draining this cycle
    logic out_free;

    assign out_free = !main_valid || m_meta.ready;
    // ready comes straight from a flop
    assign s_meta.ready = !skid_valid;
    assign m_meta.valid = main_valid;
    assign m_meta.data = main_data;

    always_ff @(posedge aclk) begin
        if (rst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            // skid drains first, input is blocked meanwhile
            main_valid <= skid_valid || s_meta.valid;
            skid_valid <= 1'b0;
        end else if (s_meta.valid && !skid_valid) begin
            // output stalled, park the incoming item
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (out_free) begin
            main_data <= skid_valid ? skid_data : s_meta.data;
        end
        if (!out_free && !skid_valid) begin
            skid_data <= s_meta.data;
        end
    end

endmodule

`default_nettype wire

// File: logic/dreq_fifo.sv
/*
 * host request queue
 * circular buffer with pointers and count, head held in an output register
 */
`timescale 1ns/10ps
`default_nettype none

module dreq_fifo #(
    parameter int QDEPTH = 8
) (
    input  wire                       aclk,
    input  wire                       rst,
    input  wire                       in_valid,
    output logic                      in_ready,
    input  wire net_types_pkg::dreq_t in_data,
    meta_intf.m                       m_req
);

    localparam int PTR_BITS = $clog2(QDEPTH);
    localparam logic [PTR_BITS:0] FULL_CNT = (PTR_BITS + 1)'(QDEPTH);

    // storage
    net_types_pkg::dreq_t mem [QDEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    // entries in mem, head register not counted
    logic [PTR_BITS:0] count;

    // head register
    logic head_valid;
    net_types_pkg::dreq_t head_data;

    logic push;
    logic pop;

    assign in_ready = (count != FULL_CNT);
    assign push = in_valid && in_ready;
    // refill the head when it is empty or leaving
    assign pop = (count != '0) && (!head_valid || m_req.ready);

    assign m_req.valid = head_valid;
    assign m_req.data = head_data;

    always_ff @(posedge aclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            head_valid <= 1'b0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            if (pop) begin
                head_valid <= 1'b1;
            end else if (m_req.ready) begin
                head_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
        if (pop) begin
            head_data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: logic/dreq_mux_net.sv
/*
 * stream router for queued host requests
 * rdma requests go out whole, tcp requests as session, address and length
 * each path leaves through its own register slice
 */
`timescale 1ns/10ps
`default_nettype none

module dreq_mux_net (
    input  wire   aclk,
    input  wire   rst,
    meta_intf.s   s_req,
    meta_intf.m   m_req_rdma,
    meta_intf.m   m_req_tcp
);

    // per path, before the slices
    meta_intf #(.DATA_BITS($bits(net_types_pkg::dreq_t))) rdma_int ();
    meta_intf #(.DATA_BITS($bits(net_types_pkg::tcp_req_t))) tcp_int ();

    net_types_pkg::dreq_t req;
    net_types_pkg::tcp_req_t tcp_fields;

    assign req = s_req.data;

    // steer valid to one path and hand back its ready
    always_comb begin
        s_req.ready = 1'b0;
        rdma_int.valid = 1'b0;
        tcp_int.valid = 1'b0;
        if (s_req.valid) begin
            if (req.strm == net_cfg_pkg::STRM_RDMA) begin
                rdma_int.valid = 1'b1;
                s_req.ready = rdma_int.ready;
            end else if (req.strm == net_cfg_pkg::STRM_TCP) begin
                tcp_int.valid = 1'b1;
                s_req.ready = tcp_int.ready;
            end
        end
    end

    // tcp reading of the context word
    assign tcp_fields.sid = req.ctx.tcp.sid;
    assign tcp_fields.vaddr = req.vaddr;
    assign tcp_fields.len = req.len;

    assign rdma_int.data = req;
    assign tcp_int.data = tcp_fields;

    meta_reg #(
        .DATA_BITS($bits(net_types_pkg::dreq_t))
    ) i_reg_rdma (
        .aclk   (aclk),
        .rst    (rst),
        .s_meta (rdma_int),
        .m_meta (m_req_rdma)
    );

    meta_reg #(
        .DATA_BITS($bits(net_types_pkg::tcp_req_t))
    ) i_reg_tcp (
        .aclk   (aclk),
        .rst    (rst),
        .s_meta (tcp_int),
        .m_meta (m_req_tcp)
    );

endmodule

`default_nettype wire

// File: logic/rdma_psn_seq.sv
/*
 * rdma sequencer
 * per queue pair PSN table, stamps each request with the current PSN
 * and advances it by the packet count of the request
 */
`timescale 1ns/10ps
`default_nettype none

module rdma_psn_seq #(
    parameter int N_QP = 16,
    parameter int PMTU_BYTES = 1024
) (
    input  wire                      aclk,
    input  wire                      rst,
    meta_intf.s                      s_req,
    output logic                     out_valid,
    input  wire                      out_ready,
    output net_types_pkg::rdma_out_t out_data
);

    localparam int IDX_BITS = $clog2(N_QP);
    localparam int MTU_SHIFT = $clog2(PMTU_BYTES);
    // low length bits below one mtu
    localparam logic [net_cfg_pkg::LEN_BITS-1:0] MTU_MASK =
        (net_cfg_pkg::LEN_BITS)'(PMTU_BYTES - 1);

    net_types_pkg::dreq_t req;
    logic [IDX_BITS-1:0] idx;
    logic [net_cfg_pkg::LEN_BITS-1:0] pkt_cnt;
    logic [net_cfg_pkg::PSN_BITS-1:0] psn_tab [N_QP];
    logic accept;

    assign req = s_req.data;
    // table slot from the low qpn bits
    assign idx = req.ctx.rdma.qpn[IDX_BITS-1:0];
    // output stage frees up in the cycle it is read
    assign s_req.ready = !out_valid || out_ready;
    assign accept = s_req.valid && s_req.ready;

    // packets = ceil(len / pmtu), at least one
    always_comb begin
        pkt_cnt = req.len >> MTU_SHIFT;
        if ((req.len & MTU_MASK) != '0) begin
            pkt_cnt = pkt_cnt + 1'b1;
        end
        if (pkt_cnt == '0) begin
            pkt_cnt = {{(net_cfg_pkg::LEN_BITS - 1){1'b0}}, 1'b1};
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            out_valid <= 1'b0;
            for (int i = 0; i < N_QP; i++) begin
                psn_tab[i] <= '0;
            end
        end else begin
            if (accept) begin
                out_valid <= 1'b1;
                // psn wraps at its own width
                psn_tab[idx] <= psn_tab[idx] + pkt_cnt[net_cfg_pkg::PSN_BITS-1:0];
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            out_data.req <= req;
            out_data.psn <= psn_tab[idx];
        end
    end

endmodule

`default_nettype wire

// File: logic/tcp_seq_track.sv
/*
 * tcp sequencer
 * per session byte sequence table, stamps each request with the
 * current sequence number and advances it by the request length
 */
`timescale 1ns/10ps
`default_nettype none

module tcp_seq_track #(
    parameter int N_SID = 16
) (
    input  wire                     aclk,
    input  wire                     rst,
    meta_intf.s                     s_req,
    output logic                    out_valid,
    input  wire                     out_ready,
    output net_types_pkg::tcp_out_t out_data
);

    localparam int IDX_BITS = $clog2(N_SID);

    net_types_pkg::tcp_req_t req;
    logic [IDX_BITS-1:0] idx;
    // length widened to the sequence width
    logic [net_cfg_pkg::SEQ_BITS-1:0] len_ext;
    logic [net_cfg_pkg::SEQ_BITS-1:0] seq_tab [N_SID];
    logic accept;

    assign req = s_req.data;
    assign idx = req.sid[IDX_BITS-1:0];
    assign len_ext = {{(net_cfg_pkg::SEQ_BITS - net_cfg_pkg::LEN_BITS){1'b0}}, req.len};

    // accept while empty or while the current item leaves
    assign s_req.ready = !out_valid || out_ready;
    assign accept = s_req.valid && s_req.ready;

    always_ff @(posedge aclk) begin
        if (rst) begin
            out_valid <= 1'b0;
            for (int i = 0; i < N_SID; i++) begin
                seq_tab[i] <= '0;
            end
        end else begin
            if (accept) begin
                out_valid <= 1'b1;
                // modulo 2^32, wraps like the tcp sequence space
                seq_tab[idx] <= seq_tab[idx] + len_ext;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // payload, no reset
    always_ff @(posedge aclk) begin
        if (accept) begin
            out_data.req <= req;
            out_data.seq <= seq_tab[idx];
        end
    end

endmodule

`default_nettype wire

// File: logic/net_dreq_top.sv
/*
 * host request router top level
 * host port -> request queue -> stream router -> rdma / tcp sequencers
 * plain ports on all sides
 */
`timescale 1ns/10ps
`default_nettype none

module net_dreq_top #(
    parameter int QDEPTH = 8,
    parameter int N_QP = 16,
    parameter int N_SID = 16,
    parameter int PMTU_BYTES = 1024
) (
    input  wire                                    aclk,
    input  wire                                    rst,

    // host requests
    input  wire                                    host_valid,
    output logic                                   host_ready,
    input  wire  [net_cfg_pkg::STRM_BITS-1:0]      host_strm,
    input  wire  [net_cfg_pkg::CTX_BITS-1:0]       host_ctx,
    input  wire  [net_cfg_pkg::VADDR_BITS-1:0]     host_vaddr,
    input  wire  [net_cfg_pkg::LEN_BITS-1:0]       host_len,

    // rdma path
    output logic                                   rdma_valid,
    input  wire                                    rdma_ready,
    output logic [net_cfg_pkg::OPC_BITS-1:0]       rdma_opcode,
    output logic [net_cfg_pkg::QPN_BITS-1:0]       rdma_qpn,
    output logic [net_cfg_pkg::VADDR_BITS-1:0]     rdma_vaddr,
    output logic [net_cfg_pkg::LEN_BITS-1:0]       rdma_len,
    output logic [net_cfg_pkg::PSN_BITS-1:0]       rdma_psn,

    // tcp path
    output logic                                   tcp_valid,
    input  wire                                    tcp_ready,
    output logic [net_cfg_pkg::CTX_BITS-1:0]       tcp_sid,
    output logic [net_cfg_pkg::VADDR_BITS-1:0]     tcp_vaddr,
    output logic [net_cfg_pkg::LEN_BITS-1:0]       tcp_len,
    output logic [net_cfg_pkg::SEQ_BITS-1:0]       tcp_seq
);

    net_types_pkg::dreq_t host_req;
    net_types_pkg::rdma_out_t rdma_out;
    net_types_pkg::tcp_out_t tcp_out;

    // queue head, and the two routed paths
    meta_intf #(.DATA_BITS($bits(net_types_pkg::dreq_t))) q_req ();
    meta_intf #(.DATA_BITS($bits(net_types_pkg::dreq_t))) rdma_req ();
    meta_intf #(.DATA_BITS($bits(net_types_pkg::tcp_req_t))) tcp_req ();

    // pack host fields, context stays undecoded here
    assign host_req.strm = host_strm;
    assign host_req.ctx = net_types_pkg::ctx_u'(host_ctx);
    assign host_req.vaddr = host_vaddr;
    assign host_req.len = host_len;

    dreq_fifo #(
        .QDEPTH (QDEPTH)
    ) i_fifo (
        .aclk     (aclk),
        .rst      (rst),
        .in_valid (host_valid),
        .in_ready (host_ready),
        .in_data  (host_req),
        .m_req    (q_req)
    );

    dreq_mux_net i_mux (
        .aclk       (aclk),
        .rst        (rst),
        .s_req      (q_req),
        .m_req_rdma (rdma_req),
        .m_req_tcp  (tcp_req)
    );

    rdma_psn_seq #(
        .N_QP       (N_QP),
        .PMTU_BYTES (PMTU_BYTES)
    ) i_rdma_seq (
        .aclk      (aclk),
        .rst       (rst),
        .s_req     (rdma_req),
        .out_valid (rdma_valid),
        .out_ready (rdma_ready),
        .out_data  (rdma_out)
    );

    tcp_seq_track #(
        .N_SID (N_SID)
    ) i_tcp_seq (
        .aclk      (aclk),
        .rst       (rst),
        .s_req     (tcp_req),
        .out_valid (tcp_valid),
        .out_ready (tcp_ready),
        .out_data  (tcp_out)
    );

    // unpack, rdma reading of the context
    assign rdma_opcode = rdma_out.req.ctx.rdma.opcode;
    assign rdma_qpn = rdma_out.req.ctx.rdma.qpn;
    assign rdma_vaddr = rdma_out.req.vaddr;
    assign rdma_len = rdma_out.req.len;
    assign rdma_psn = rdma_out.psn;

    assign tcp_sid = tcp_out.req.sid;
    assign tcp_vaddr = tcp_out.req.vaddr;
    assign tcp_len = tcp_out.req.len;
    assign tcp_seq = tcp_out.seq;

endmodule

`default_nettype wire

// File: verification/tb_net_dreq.sv
/*
 * testbench for the host request router
 *   clock, reset and host stimulus from the cases file
 *   random output ready with stall phases per path
 *   reference PSN and sequence tables, compare tasks, watchdog
 */
`timescale 1ns/10ps
`default_nettype none

module tb_net_dreq;

    localparam int CLK_PERIOD = 4;
    localparam int QDEPTH = 8;
    localparam int N_QP = 16;
    localparam int N_SID = 16;
    localparam int PMTU_BYTES = 1024;
    localparam int MAX_CASES = 64;
    // watchdog budget per request
    localparam int CYCLES_PER_CASE = 40;

    logic aclk = 1'b0;
    logic rst;
    logic host_valid;
    logic host_ready;
    logic [net_cfg_pkg::STRM_BITS-1:0] host_strm;
    logic [net_cfg_pkg::CTX_BITS-1:0] host_ctx;
    logic [net_cfg_pkg::VADDR_BITS-1:0] host_vaddr;
    logic [net_cfg_pkg::LEN_BITS-1:0] host_len;
    logic rdma_valid;
    logic rdma_ready = 1'b0;
    logic [net_cfg_pkg::OPC_BITS-1:0] rdma_opcode;
    logic [net_cfg_pkg::QPN_BITS-1:0] rdma_qpn;
    logic [net_cfg_pkg::VADDR_BITS-1:0] rdma_vaddr;
    logic [net_cfg_pkg::LEN_BITS-1:0] rdma_len;
    logic [net_cfg_pkg::PSN_BITS-1:0] rdma_psn;
    logic tcp_valid;
    logic tcp_ready = 1'b0;
    logic [net_cfg_pkg::CTX_BITS-1:0] tcp_sid;
    logic [net_cfg_pkg::VADDR_BITS-1:0] tcp_vaddr;
    logic [net_cfg_pkg::LEN_BITS-1:0] tcp_len;
    logic [net_cfg_pkg::SEQ_BITS-1:0] tcp_seq;

    // four words per request: stream, ctx, vaddr, len
    logic [63:0] words [MAX_CASES*4];
    int n_cases = 0;
    integer seed = 71;
    logic [31:0] rnd_word;
    int run_cycles;
    int rst_edges = 0;
    bit saw_full = 1'b0;

    // reference model tables and expected outputs per stream
    logic [net_cfg_pkg::PSN_BITS-1:0] psn_model [N_QP];
    logic [net_cfg_pkg::SEQ_BITS-1:0] seq_model [N_SID];
    logic [63:0] pkts;
    int slot;
    net_types_pkg::rdma_out_t exp_rdma [$];
    net_types_pkg::tcp_out_t exp_tcp [$];
    net_types_pkg::rdma_out_t new_rdma;
    net_types_pkg::tcp_out_t new_tcp;
    net_types_pkg::rdma_out_t act_rdma;
    net_types_pkg::tcp_out_t act_tcp;

    net_dreq_top #(
        .QDEPTH     (QDEPTH),
        .N_QP       (N_QP),
        .N_SID      (N_SID),
        .PMTU_BYTES (PMTU_BYTES)
    ) i_dut (
        .aclk        (aclk),
        .rst         (rst),
        .host_valid  (host_valid),
        .host_ready  (host_ready),
        .host_strm   (host_strm),
        .host_ctx    (host_ctx),
        .host_vaddr  (host_vaddr),
        .host_len    (host_len),
        .rdma_valid  (rdma_valid),
        .rdma_ready  (rdma_ready),
        .rdma_opcode (rdma_opcode),
        .rdma_qpn    (rdma_qpn),
        .rdma_vaddr  (rdma_vaddr),
        .rdma_len    (rdma_len),
        .rdma_psn    (rdma_psn),
        .tcp_valid   (tcp_valid),
        .tcp_ready   (tcp_ready),
        .tcp_sid     (tcp_sid),
        .tcp_vaddr   (tcp_vaddr),
        .tcp_len     (tcp_len),
        .tcp_seq     (tcp_seq)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    task automatic fail_run(input string why);
        $display("Result: FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] want,
                                   input logic [63:0] got);
        $display("[ERROR] time %0t: %s expected 0x%0h, actual 0x%0h", $time, name, want, got);
        fail_run("output value mismatch");
    endtask

    // packets per request, ceil(len / mtu) and never below one
    function automatic logic [63:0] packet_count(input logic [63:0] len);
        logic [63:0] n;
        n = (len + 64'(PMTU_BYTES) - 64'd1) / 64'(PMTU_BYTES);
        if (n == 64'd0) begin
            n = 64'd1;
        end
        return n;
    endfunction

    task automatic check_rdma(input net_types_pkg::rdma_out_t want,
                              input net_types_pkg::rdma_out_t got);
        if (got.req.ctx.rdma.opcode !== want.req.ctx.rdma.opcode) begin
            report_mismatch("rdma_opcode", 64'(want.req.ctx.rdma.opcode),
                            64'(got.req.ctx.rdma.opcode));
        end else if (got.req.ctx.rdma.qpn !== want.req.ctx.rdma.qpn) begin
            report_mismatch("rdma_qpn", 64'(want.req.ctx.rdma.qpn), 64'(got.req.ctx.rdma.qpn));
        end else if (got.req.vaddr !== want.req.vaddr) begin
            report_mismatch("rdma_vaddr", 64'(want.req.vaddr), 64'(got.req.vaddr));
        end else if (got.req.len !== want.req.len) begin
            report_mismatch("rdma_len", 64'(want.req.len), 64'(got.req.len));
        end else if (got.psn !== want.psn) begin
            report_mismatch("rdma_psn", 64'(want.psn), 64'(got.psn));
        end
    endtask

    task automatic check_tcp(input net_types_pkg::tcp_out_t want,
                             input net_types_pkg::tcp_out_t got);
        if (got.req.sid !== want.req.sid) begin
            report_mismatch("tcp_sid", 64'(want.req.sid), 64'(got.req.sid));
        end else if (got.req.vaddr !== want.req.vaddr) begin
            report_mismatch("tcp_vaddr", 64'(want.req.vaddr), 64'(got.req.vaddr));
        end else if (got.req.len !== want.req.len) begin
            report_mismatch("tcp_len", 64'(want.req.len), 64'(got.req.len));
        end else if (got.seq !== want.seq) begin
            report_mismatch("tcp_seq", 64'(want.seq), 64'(got.seq));
        end
    endtask

    // reference model, updated on every host transfer
    always @(posedge aclk) begin
        if (rst) begin
            for (int i = 0; i < N_QP; i++) begin
                psn_model[i] = '0;
            end
            for (int i = 0; i < N_SID; i++) begin
                seq_model[i] = '0;
            end
        end else if (host_valid && host_ready) begin
            if (host_strm == net_cfg_pkg::STRM_RDMA) begin
                // opcode sits above the qpn in the context word
                slot = int'(host_ctx[net_cfg_pkg::QPN_BITS-1:0]) % N_QP;
                new_rdma.req.strm = host_strm;
                new_rdma.req.ctx.rdma.opcode =
                    host_ctx[net_cfg_pkg::CTX_BITS-1 -: net_cfg_pkg::OPC_BITS];
                new_rdma.req.ctx.rdma.qpn = host_ctx[net_cfg_pkg::QPN_BITS-1:0];
                new_rdma.req.vaddr = host_vaddr;
                new_rdma.req.len = host_len;
                new_rdma.psn = psn_model[slot];
                pkts = packet_count(64'(host_len));
                psn_model[slot] = psn_model[slot] + pkts[net_cfg_pkg::PSN_BITS-1:0];
                exp_rdma.push_back(new_rdma);
            end else begin
                slot = int'(host_ctx) % N_SID;
                new_tcp.req.sid = host_ctx;
                new_tcp.req.vaddr = host_vaddr;
                new_tcp.req.len = host_len;
                new_tcp.seq = seq_model[slot];
                // byte sequence wraps modulo 2^32
                seq_model[slot] = seq_model[slot] + 32'(host_len);
                exp_tcp.push_back(new_tcp);
            end
        end
        if (!rst && !host_ready) begin
            saw_full = 1'b1;
        end
    end

    // output monitor
    always @(posedge aclk) begin
        if (rst) begin
            rst_edges = rst_edges + 1;
            // flops hold reset values from the second reset edge on
            if (rst_edges > 1 && (rdma_valid || tcp_valid)) begin
                fail_run("a valid output was high during reset");
            end
        end else begin
            if (rdma_valid && rdma_ready) begin
                act_rdma.req.strm = net_cfg_pkg::STRM_RDMA;
                act_rdma.req.ctx.rdma.opcode = rdma_opcode;
                act_rdma.req.ctx.rdma.qpn = rdma_qpn;
                act_rdma.req.vaddr = rdma_vaddr;
                act_rdma.req.len = rdma_len;
                act_rdma.psn = rdma_psn;
                if (exp_rdma.size() == 0) begin
                    fail_run("rdma output appeared with no rdma request pending");
                end else begin
                    check_rdma(exp_rdma.pop_front(), act_rdma);
                end
            end
            if (tcp_valid && tcp_ready) begin
                act_tcp.req.sid = tcp_sid;
                act_tcp.req.vaddr = tcp_vaddr;
                act_tcp.req.len = tcp_len;
                act_tcp.seq = tcp_seq;
                if (exp_tcp.size() == 0) begin
                    fail_run("tcp output appeared with no tcp request pending");
                end else begin
                    check_tcp(exp_tcp.pop_front(), act_tcp);
                end
            end
        end
    end

    // output ready, with stall phases counted from reset release
    always @(posedge aclk) begin
        if (rst) begin
            run_cycles <= 0;
            rdma_ready <= 1'b0;
            tcp_ready <= 1'b0;
        end else begin
            run_cycles <= run_cycles + 1;
            rnd_word = $random(seed);
            if (run_cycles < 40) begin
                // rdma stalled, tcp keeps moving
                rdma_ready <= 1'b0;
                tcp_ready <= rnd_word[0];
            end else if (run_cycles < 70) begin
                rdma_ready <= 1'b0;
                tcp_ready <= 1'b0;
            end else if (run_cycles < 100) begin
                rdma_ready <= rnd_word[1];
                tcp_ready <= 1'b0;
            end else begin
                rdma_ready <= rnd_word[1];
                tcp_ready <= rnd_word[2];
            end
        end
    end

    initial begin
        wait (n_cases > 0);
        #(n_cases * CYCLES_PER_CASE * CLK_PERIOD);
        fail_run("watchdog expired before all requests came out");
    end

    initial begin
        rst = 1'b1;
        host_valid = 1'b0;
        host_strm = '0;
        host_ctx = '0;
        host_vaddr = '0;
        host_len = '0;
        // marker words past the end of the file, unique per address
        for (int i = 0; i < MAX_CASES * 4; i++) begin
            words[i] = {16'hffff, 48'(i)};
        end
        $readmemh("verification/net_dreq_cases.txt", words);
        while (n_cases < MAX_CASES && words[4 * n_cases] <= 64'd1) begin
            n_cases++;
        end
        if (n_cases == 0) begin
            fail_run("no requests found in the cases file");
        end
        repeat (5) @(posedge aclk);
        rst <= 1'b0;
        @(posedge aclk);
        if (!host_ready) begin
            fail_run("host_ready stayed low after reset release");
        end else if (rdma_valid || tcp_valid) begin
            fail_run("a valid output was high right after reset");
        end
        for (int i = 0; i < n_cases; i++) begin
            host_valid <= 1'b1;
            host_strm <= words[4 * i][net_cfg_pkg::STRM_BITS-1:0];
            host_ctx <= words[4 * i + 1][net_cfg_pkg::CTX_BITS-1:0];
            host_vaddr <= words[4 * i + 2][net_cfg_pkg::VADDR_BITS-1:0];
            host_len <= words[4 * i + 3][net_cfg_pkg::LEN_BITS-1:0];
            @(posedge aclk);
            while (!host_ready) begin
                @(posedge aclk);
            end
        end
        host_valid <= 1'b0;
        // let the model take the last transfer before looking at the queues
        @(posedge aclk);
        while (exp_rdma.size() != 0 || exp_tcp.size() != 0) begin
            @(posedge aclk);
        end
        // idle window to catch extra outputs
        repeat (20) @(posedge aclk);
        if (!saw_full) begin
            fail_run("host_ready never fell, the queue did not fill");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verification/net_dreq_cases.txt
// columns: stream ctx vaddr len, all hex, one request per line
// stream 0 is rdma with ctx = opcode(4) qpn(12), stream 1 is tcp with ctx = session id
0 4003 000010000000 0000000
1 0007 000020000000 FFFFFFF
0 4003 000010001000 0000400
0 6005 000030000000 0000800
1 0002 000040000000 0000123
0 4003 000010002000 0000401
1 0007 000020100000 FFFFFFF
0 A00A 000050000000 0000001
0 6005 000030001000 0000C00
1 0007 000020200000 FFFFFFF
1 0002 000040001000 0000010
0 4003 000010003000 FFFFFFF
1 0007 000020300000 FFFFFFF
1 0007 000020400000 FFFFFFF
1 0007 000020500000 FFFFFFF
0 A00A 000050001000 0000400
1 0007 000020600000 FFFFFFF
1 0007 000020700000 FFFFFFF
1 0007 000020800000 FFFFFFF
1 0007 000020900000 FFFFFFF
0 6005 000030002000 0001000
1 0007 000020A00000 FFFFFFF
1 0007 000020B00000 FFFFFFF
1 0007 000020C00000 FFFFFFF
1 0002 000040002000 0000001
1 0007 000020D00000 FFFFFFF
1 0007 000020E00000 FFFFFFF
1 0007 000020F00000 FFFFFFF
0 4003 000010004000 0000000
1 0007 000021000000 FFFFFFF
1 0007 000021100000 FFFFFFF

// File: net_dreq_top.f
logic/net_cfg_pkg.sv
logic/net_types_pkg.sv
logic/meta_intf.sv
logic/meta_reg.sv
logic/dreq_fifo.sv
logic/dreq_mux_net.sv
logic/rdma_psn_seq.sv
logic/tcp_seq_track.sv
logic/net_dreq_top.sv
verification/tb_net_dreq.sv

// File: run.sh
#!/bin/sh
# build and run the request router testbench with Verilator
# the cases file path is relative to the project root, so run from there

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f net_dreq_top.f --top-module tb_net_dreq -o sim_net_dreq
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_net_dreq
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0
